// ==== all.f ====
rtl/fcore_pkg.sv
rtl/program_loader.sv
rtl/program_memory.sv
rtl/register_file.sv
rtl/execution_unit.sv
rtl/fcore_lite.sv
tb/fcore_lite_chk.sv
tb/fcore_lite_tb.sv

// ==== rtl/execution_unit.sv ====
/*
 * Three cycles per instruction: fetch, decode, execute.
 * Execution starts at word 0 and ends on a stop or after the last word.
 * A run pulse is ignored unless the unit is idle.
 */
`timescale 1ns/1ns
module execution_unit import fcore_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       run,
    output prog_addr_t fetch_address,
    input  instr_t     instr,
    output reg_addr_t  read_a_address,
    output reg_addr_t  read_b_address,
    input  data_t      read_a_data,
    input  data_t      read_b_data,
    output logic       write,
    output reg_addr_t  write_address,
    output data_t      write_data,
    output logic       busy,
    output logic       done
);

    localparam prog_addr_t LAST_ADDRESS = prog_addr_t'(PROG_DEPTH - 1);

    exec_state_t state;
    prog_addr_t  pc;
    instr_t      ir;
    opcode_t     opcode;
    logic [15:0] imm;
    data_t       result;
    logic        has_result;
    logic        finish;

    assign opcode = instr_opcode(ir);
    assign imm    = instr_imm(ir);
    assign finish = (opcode == op_stop) || (pc == LAST_ADDRESS);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
            pc    <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (run) begin
                        pc    <= '0;
                        state <= st_fetch;
                    end
                end
                st_fetch: state <= st_decode;
                st_decode: state <= st_execute;
                st_execute: begin
                    if (finish) begin
                        state <= st_done;
                    end else begin
                        pc    <= pc + 1'b1;
                        state <= st_fetch;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // The fetched word is on the memory output during decode
    always_ff @(posedge clock) begin
        if (state == st_decode)
            ir <= instr;
    end

    assign fetch_address = pc;

    assign read_a_address = instr_src_a(ir);
    assign read_b_address = instr_src_b(ir);

    always_comb begin
        result     = '0;
        has_result = 1'b1;
        case (opcode)
            op_add: result = read_a_data + read_b_data;
            op_sub: result = read_a_data - read_b_data;
            // Only the low half of the product is kept
            op_mul: result = read_a_data * read_b_data;
            op_and: result = read_a_data & read_b_data;
            op_or:  result = read_a_data | read_b_data;
            op_xor: result = read_a_data ^ read_b_data;
            op_ldi: result = {{16{imm[15]}}, imm};
            op_shl: result = read_a_data << read_b_data[4:0];
            default: has_result = 1'b0;
        endcase
    end

    // Stop and unused codes leave the registers untouched
    assign write         = (state == st_execute) && has_result;
    assign write_address = instr_dest(ir);
    assign write_data    = result;

    assign busy = (state != st_idle);
    assign done = (state == st_done);

endmodule

// ==== rtl/fcore_lite.sv ====
/*
 * Lite arithmetic core: Wishbone program loading, common-io register
 * access, and a run/done handshake. Register writes through common-io
 * are refused while the core is busy.
 */
`timescale 1ns/1ns
module fcore_lite import fcore_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [31:0] wb_adr,
    input  data_t      wb_write_data,
    output data_t      wb_read_data,
    output logic       wb_ack,
    output logic       wb_err,
    input  logic       run,
    output logic       done,
    output logic       busy,
    input  logic       dma_write_valid,
    input  reg_addr_t  dma_write_address,
    input  data_t      dma_write_data,
    output logic       dma_write_ready,
    input  logic       dma_read_valid,
    input  reg_addr_t  dma_read_address,
    output logic       dma_read_response_valid,
    output data_t      dma_read_response_data
);

    logic       mem_write;
    prog_addr_t mem_address;
    instr_t     mem_write_data;
    instr_t     mem_read_data;
    prog_addr_t fetch_address;
    instr_t     fetch_instr;
    reg_addr_t  read_a_address;
    reg_addr_t  read_b_address;
    data_t      read_a_data;
    data_t      read_b_data;
    logic       core_write;
    reg_addr_t  core_write_address;
    data_t      core_write_data;
    logic       dma_write;

    // Keeping DMA out while running means the two write ports never collide
    assign dma_write_ready = ~busy;
    assign dma_write       = dma_write_valid && dma_write_ready;

    program_loader loader (
        .clock(clock),
        .reset(reset),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_write_data(wb_write_data),
        .wb_read_data(wb_read_data),
        .wb_ack(wb_ack),
        .wb_err(wb_err),
        .busy(busy),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_read_data(mem_read_data),
        .mem_write_data(mem_write_data)
    );

    program_memory memory (
        .clock(clock),
        .a_write(mem_write),
        .a_address(mem_address),
        .a_write_data(mem_write_data),
        .a_read_data(mem_read_data),
        .b_address(fetch_address),
        .b_read_data(fetch_instr)
    );

    execution_unit core (
        .clock(clock),
        .reset(reset),
        .run(run),
        .fetch_address(fetch_address),
        .instr(fetch_instr),
        .read_a_address(read_a_address),
        .read_b_address(read_b_address),
        .read_a_data(read_a_data),
        .read_b_data(read_b_data),
        .write(core_write),
        .write_address(core_write_address),
        .write_data(core_write_data),
        .busy(busy),
        .done(done)
    );

    register_file registers (
        .clock(clock),
        .reset(reset),
        .core_read_a_address(read_a_address),
        .core_read_b_address(read_b_address),
        .core_read_a_data(read_a_data),
        .core_read_b_data(read_b_data),
        .core_write(core_write),
        .core_write_address(core_write_address),
        .core_write_data(core_write_data),
        .dma_write(dma_write),
        .dma_write_address(dma_write_address),
        .dma_write_data(dma_write_data),
        .dma_read_valid(dma_read_valid),
        .dma_read_address(dma_read_address),
        .dma_read_response_valid(dma_read_response_valid),
        .dma_read_response_data(dma_read_response_data)
    );

endmodule

// ==== rtl/fcore_pkg.sv ====
/*
 * Shared widths, types and opcodes for the lite arithmetic core.
 * All arithmetic is 32-bit two's complement with wraparound.
 * Opcodes not listed in opcode_t decode as no-operation.
 */
package fcore_pkg;

    localparam int DATA_WIDTH = 32;
    localparam int PROG_DEPTH = 64;
    localparam int REG_COUNT  = 16;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [31:0] instr_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [5:0]  prog_addr_t;

    typedef enum logic [3:0] {
        op_stop = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_mul  = 4'd3,
        op_and  = 4'd4,
        op_or   = 4'd5,
        op_xor  = 4'd6,
        op_ldi  = 4'd7,
        op_shl  = 4'd8
    } opcode_t;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_execute,
        st_done
    } exec_state_t;

    // An instruction holds opcode, dest, src A and src B, then a 16 bit immediate
    function automatic opcode_t instr_opcode(instr_t i);
        return opcode_t'(i[31:28]);
    endfunction

    function automatic reg_addr_t instr_dest(instr_t i);
        return i[27:24];
    endfunction

    function automatic reg_addr_t instr_src_a(instr_t i);
        return i[23:20];
    endfunction

    function automatic reg_addr_t instr_src_b(instr_t i);
        return i[19:16];
    endfunction

    function automatic logic [15:0] instr_imm(instr_t i);
        return i[15:0];
    endfunction

endpackage

// ==== rtl/program_loader.sv ====
/*
 * Wishbone classic slave in front of the program memory.
 * Only byte addresses below 256 are valid; anything higher gets err.
 * The host must hold the request stable until ack or err.
 */
`timescale 1ns/1ns
module program_loader import fcore_pkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [31:0] wb_adr,
    input  data_t      wb_write_data,
    output data_t      wb_read_data,
    output logic       wb_ack,
    output logic       wb_err,
    input  logic       busy,
    output logic       mem_write,
    output prog_addr_t mem_address,
    input  instr_t     mem_read_data,
    output instr_t     mem_write_data
);

    typedef enum logic [1:0] {
        ld_idle,
        ld_wait,
        ld_ack,
        ld_err
    } loader_state_t;

    loader_state_t state;
    logic request;
    logic out_of_range;

    assign request      = wb_cyc && wb_stb;
    assign out_of_range = |wb_adr[31:8];

    // A new request is only taken from idle, so each one is answered once
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ld_idle;
        end else begin
            case (state)
                ld_idle: begin
                    if (request) begin
                        if (out_of_range)
                            state <= ld_err;
                        else if (busy)
                            state <= ld_wait;
                        else
                            state <= ld_ack;
                    end
                end
                ld_wait: begin
                    // The core owns the program while it runs
                    if (!request)
                        state <= ld_idle;
                    else if (!busy)
                        state <= ld_ack;
                end
                default: state <= ld_idle;
            endcase
        end
    end

    // The address goes to memory straight away, so read data is ready with ack
    assign mem_address    = wb_adr[7:2];
    assign mem_write      = (state == ld_ack) && wb_we;
    assign mem_write_data = wb_write_data;

    assign wb_ack       = (state == ld_ack);
    assign wb_err       = (state == ld_err);
    assign wb_read_data = mem_read_data;

endmodule

// ==== rtl/program_memory.sv ====
/*
 * Program store with one read/write port and one read port.
 * Both reads are registered; a read during a write of the same word
 * returns the previous contents. The array has no reset.
 */
`timescale 1ns/1ns
module program_memory import fcore_pkg::*; (
    input  logic       clock,
    input  logic       a_write,
    input  prog_addr_t a_address,
    input  instr_t     a_write_data,
    output instr_t     a_read_data,
    input  prog_addr_t b_address,
    output instr_t     b_read_data
);

    instr_t words [PROG_DEPTH];

    // Port A serves the loader
    always_ff @(posedge clock) begin
        if (a_write)
            words[a_address] <= a_write_data;
        a_read_data <= words[a_address];
    end

    // Port B is the instruction fetch path
    always_ff @(posedge clock) begin
        b_read_data <= words[b_address];
    end

endmodule

// ==== rtl/register_file.sv ====
/*
 * Sixteen 32-bit registers shared by the core and the common-io ports.
 * Core and DMA writes must not coincide; the top level ensures this.
 * The DMA read response comes exactly one cycle after the request.
 */
`timescale 1ns/1ns
module register_file import fcore_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  reg_addr_t core_read_a_address,
    input  reg_addr_t core_read_b_address,
    output data_t     core_read_a_data,
    output data_t     core_read_b_data,
    input  logic      core_write,
    input  reg_addr_t core_write_address,
    input  data_t     core_write_data,
    input  logic      dma_write,
    input  reg_addr_t dma_write_address,
    input  data_t     dma_write_data,
    input  logic      dma_read_valid,
    input  reg_addr_t dma_read_address,
    output logic      dma_read_response_valid,
    output data_t     dma_read_response_data
);

    data_t regs [REG_COUNT];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end else if (core_write) begin
            regs[core_write_address] <= core_write_data;
        end else if (dma_write) begin
            regs[dma_write_address] <= dma_write_data;
        end
    end

    // Operand reads feed the ALU in the same cycle
    assign core_read_a_data = regs[core_read_a_address];
    assign core_read_b_data = regs[core_read_b_address];

    always_ff @(posedge clock) begin
        if (reset)
            dma_read_response_valid <= 1'b0;
        else
            dma_read_response_valid <= dma_read_valid;
    end

    always_ff @(posedge clock) begin
        if (dma_read_valid)
            dma_read_response_data <= regs[dma_read_address];
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module fcore_lite_tb -f all.f -o fcore_lite_sim

./obj_dir/fcore_lite_sim +verilator+error+limit+100 | tee sim.log

if grep -q '^TEST PASS$' sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// ==== tb/fcore_lite_chk.sv ====
/*
 * Handshake assertions for fcore_lite, attached by bind to the top level.
 * All checks are disabled while reset is high.
 */
`timescale 1ns/1ns
module fcore_lite_chk (
    input logic clock,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic wb_err,
    input logic run,
    input logic done,
    input logic busy,
    input logic dma_read_valid,
    input logic dma_read_response_valid,
    input logic dma_write_ready
);

    int assertion_failures = 0;

    // A response is either ack or err, and only to an open request
    ack_err_exclusive: assert property (@(posedge clock) disable iff (reset)
        (wb_ack || wb_err) |-> (wb_cyc && wb_stb && !(wb_ack && wb_err)))
        else begin
            assertion_failures++;
            $error("Wishbone response is not a single ack or err to an open request");
        end

    // A run ends with exactly one cycle of done
    done_single_cycle: assert property (@(posedge clock) disable iff (reset)
        done |=> !done)
        else begin
            assertion_failures++;
            $error("done stayed high for more than one cycle");
        end

    read_response_follows: assert property (@(posedge clock) disable iff (reset)
        dma_read_valid |=> dma_read_response_valid)
        else begin
            assertion_failures++;
            $error("No common-io read response one cycle after the request");
        end

    // A run taken from idle makes the core busy and closes the write port
    ready_low_after_run: assert property (@(posedge clock) disable iff (reset)
        (run && !busy) |=> (busy && !dma_write_ready))
        else begin
            assertion_failures++;
            $error("dma_write_ready stayed high after a run was accepted");
        end

endmodule

bind fcore_lite fcore_lite_chk handshake_chk (
    .clock(clock),
    .reset(reset),
    .wb_cyc(wb_cyc),
    .wb_stb(wb_stb),
    .wb_ack(wb_ack),
    .wb_err(wb_err),
    .run(run),
    .done(done),
    .busy(busy),
    .dma_read_valid(dma_read_valid),
    .dma_read_response_valid(dma_read_response_valid),
    .dma_write_ready(dma_write_ready)
);

// ==== tb/fcore_lite_tb.sv ====
/*
 * Directed tests for fcore_lite: program loading over Wishbone, operand
 * and result transfer over common-io, and runs checked against a model.
 * Every wait gives up after a bounded number of cycles.
 */
`timescale 1ns/1ns
module fcore_lite_tb import fcore_pkg::*; ();

    logic        clock;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_adr;
    data_t       wb_write_data;
    data_t       wb_read_data;
    logic        wb_ack;
    logic        wb_err;
    logic        run;
    logic        done;
    logic        busy;
    logic        dma_write_valid;
    reg_addr_t   dma_write_address;
    data_t       dma_write_data;
    logic        dma_write_ready;
    logic        dma_read_valid;
    reg_addr_t   dma_read_address;
    logic        dma_read_response_valid;
    data_t       dma_read_response_data;

    integer seed = 32'hefe2_bca5;
    int     timeout_cycles = 1000;
    int     value_errors = 0;
    int     timeouts = 0;
    data_t  model_regs [REG_COUNT];
    instr_t prog_image [PROG_DEPTH];
    logic   last_ack;
    logic   last_err;
    logic   ack_busy;
    data_t  last_read;
    time    ack_time;
    time    done_time;

    fcore_lite DUT (.*);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic compare_data(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_instr(input string name, input instr_t expected, input instr_t actual);
        if (actual !== expected) begin
            value_errors++;
            $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            value_errors++;
            $display("ERR %0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    function automatic instr_t encode_instr(logic [3:0] op, reg_addr_t d, reg_addr_t a,
                                            reg_addr_t b, logic [15:0] imm);
        return {op, d, a, b, imm};
    endfunction

    // Applies one instruction to the model registers; returns 1 on stop
    function automatic logic model_execute(instr_t word);
        opcode_t     op;
        reg_addr_t   d;
        data_t       a;
        data_t       b;
        logic [15:0] imm;
        op  = opcode_t'(word[31:28]);
        d   = word[27:24];
        a   = model_regs[word[23:20]];
        b   = model_regs[word[19:16]];
        imm = word[15:0];
        case (op)
            op_stop: return 1'b1;
            op_add:  model_regs[d] = a + b;
            op_sub:  model_regs[d] = a - b;
            op_mul:  model_regs[d] = a * b;
            op_and:  model_regs[d] = a & b;
            op_or:   model_regs[d] = a | b;
            op_xor:  model_regs[d] = a ^ b;
            op_ldi:  model_regs[d] = {{16{imm[15]}}, imm};
            op_shl:  model_regs[d] = a << b[4:0];
            default: ;
        endcase
        return 1'b0;
    endfunction

    // The last word behaves as a stop once it has executed
    function automatic void model_run();
        for (int i = 0; i < PROG_DEPTH; i++) begin
            if (model_execute(prog_image[i]))
                break;
        end
    endfunction

    task automatic wb_transfer(input logic we, input logic [31:0] adr, input data_t data);
        int count;
        count = 0;
        @(posedge clock);
        wb_cyc        <= 1'b1;
        wb_stb        <= 1'b1;
        wb_we         <= we;
        wb_adr        <= adr;
        wb_write_data <= data;
        do begin
            @(negedge clock);
            count++;
        end while (!wb_ack && !wb_err && count < timeout_cycles);
        last_ack  = wb_ack;
        last_err  = wb_err;
        last_read = wb_read_data;
        ack_busy  = busy;
        ack_time  = $time;
        if (!(wb_ack || wb_err)) begin
            timeouts++;
            $display("Timeout at %0t: Wishbone request to %h got neither ack nor err",
                     $time, adr);
        end
        @(posedge clock);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input logic [31:0] adr, input data_t data);
        wb_transfer(1'b1, adr, data);
    endtask

    task automatic wb_read(input logic [31:0] adr);
        wb_transfer(1'b0, adr, '0);
    endtask

    task automatic dma_write(input reg_addr_t addr, input data_t data);
        int count;
        count = 0;
        @(posedge clock);
        dma_write_valid   <= 1'b1;
        dma_write_address <= addr;
        dma_write_data    <= data;
        do begin
            @(negedge clock);
            count++;
        end while (!dma_write_ready && count < timeout_cycles);
        if (!dma_write_ready) begin
            timeouts++;
            $display("Timeout at %0t: common-io write never became ready", $time);
        end else begin
            model_regs[addr] = data;
        end
        @(posedge clock);
        dma_write_valid <= 1'b0;
    endtask

    task automatic dma_read(input reg_addr_t addr, output data_t data);
        int count;
        count = 0;
        @(posedge clock);
        dma_read_valid   <= 1'b1;
        dma_read_address <= addr;
        @(posedge clock);
        dma_read_valid <= 1'b0;
        do begin
            @(negedge clock);
            count++;
        end while (!dma_read_response_valid && count < timeout_cycles);
        if (!dma_read_response_valid) begin
            timeouts++;
            $display("Timeout at %0t: common-io read gave no response", $time);
        end
        data = dma_read_response_data;
    endtask

    task automatic run_program();
        int count;
        count = 0;
        @(posedge clock);
        run <= 1'b1;
        @(posedge clock);
        run <= 1'b0;
        do begin
            @(negedge clock);
            count++;
        end while (!done && count < timeout_cycles);
        if (!done) begin
            timeouts++;
            $display("Timeout at %0t: the core never raised done", $time);
        end
        done_time = $time;
    endtask

    task automatic load_image(input int count);
        for (int i = 0; i < count; i++) begin
            wb_write(32'(i) << 2, prog_image[i]);
            compare_flag("wb_ack", 1'b1, last_ack);
        end
    endtask

    task automatic check_registers();
        data_t value;
        for (int r = 0; r < REG_COUNT; r++) begin
            dma_read(reg_addr_t'(r), value);
            compare_data($sformatf("r%0d", r), model_regs[r], value);
        end
    endtask

    task automatic program_readback();
        instr_t words [8];
        for (int i = 0; i < 8; i++) begin
            words[i] = $random(seed);
            wb_write(32'(16 + i) << 2, words[i]);
            compare_flag("wb_ack", 1'b1, last_ack);
            compare_flag("wb_err", 1'b0, last_err);
        end
        for (int i = 0; i < 8; i++) begin
            wb_read(32'(16 + i) << 2);
            compare_flag("wb_ack", 1'b1, last_ack);
            compare_flag("wb_err", 1'b0, last_err);
            compare_instr("wb_read_data", words[i], last_read);
        end
    endtask

    task automatic out_of_range_access();
        wb_write(32'h0000_0014, 32'h1234_5678);
        compare_flag("wb_ack", 1'b1, last_ack);
        // Same low bits as word 5, so a stray write would show on readback
        wb_write(32'h0000_0114, 32'hdead_beef);
        compare_flag("wb_err", 1'b1, last_err);
        compare_flag("wb_ack", 1'b0, last_ack);
        wb_write(32'h8000_0014, 32'h0bad_f00d);
        compare_flag("wb_err", 1'b1, last_err);
        wb_read(32'h0000_0214);
        compare_flag("wb_err", 1'b1, last_err);
        wb_read(32'h0000_0014);
        compare_flag("wb_ack", 1'b1, last_ack);
        compare_instr("wb_read_data", 32'h1234_5678, last_read);
    endtask

    task automatic all_opcodes();
        dma_write(4, 32'h1234_5678);
        dma_write(5, 32'hfedc_ba98);
        prog_image[0]  = encode_instr(op_ldi, 1, 0, 0, 16'h8001);
        prog_image[1]  = encode_instr(op_add, 3, 4, 5, 0);
        prog_image[2]  = encode_instr(op_sub, 6, 4, 5, 0);
        prog_image[3]  = encode_instr(op_mul, 7, 4, 5, 0);
        prog_image[4]  = encode_instr(op_and, 8, 4, 5, 0);
        prog_image[5]  = encode_instr(op_or, 9, 4, 5, 0);
        prog_image[6]  = encode_instr(op_xor, 10, 4, 5, 0);
        prog_image[7]  = encode_instr(op_shl, 11, 4, 5, 0);
        prog_image[8]  = encode_instr(op_ldi, 2, 0, 0, 16'h7ffe);
        prog_image[9]  = encode_instr(4'hc, 12, 4, 5, 16'hffff);
        prog_image[10] = encode_instr(op_add, 13, 1, 1, 0);
        prog_image[11] = encode_instr(op_stop, 0, 0, 0, 0);
        load_image(12);
        run_program();
        model_run();
        check_registers();
    endtask

    task automatic busy_backpressure();
        int count;
        count = 0;
        for (int i = 0; i < 40; i++)
            prog_image[i] = encode_instr(op_add, 12, 12, 4, 0);
        prog_image[40] = encode_instr(op_stop, 0, 0, 0, 0);
        load_image(41);
        fork
            run_program();
            begin
                do begin
                    @(negedge clock);
                    count++;
                end while (!busy && count < timeout_cycles);
                if (!busy) begin
                    timeouts++;
                    $display("Timeout at %0t: the core never became busy", $time);
                end
                compare_flag("dma_write_ready", 1'b0, dma_write_ready);
                wb_write(32'd60 << 2, 32'hcafe_f00d);
            end
        join
        prog_image[60] = 32'hcafe_f00d;
        compare_flag("wb_ack", 1'b1, last_ack);
        compare_flag("busy", 1'b0, ack_busy);
        compare_flag("wb_ack_after_done", 1'b1, ack_time > done_time);
        model_run();
        check_registers();
        wb_read(32'd60 << 2);
        compare_instr("wb_read_data", 32'hcafe_f00d, last_read);
    endtask

    task automatic random_runs();
        prog_image[0] = encode_instr(op_add, 3, 1, 2, 0);
        prog_image[1] = encode_instr(op_sub, 4, 1, 2, 0);
        prog_image[2] = encode_instr(op_mul, 5, 1, 2, 0);
        prog_image[3] = encode_instr(op_xor, 6, 1, 2, 0);
        prog_image[4] = encode_instr(op_shl, 7, 1, 2, 0);
        prog_image[5] = encode_instr(op_stop, 0, 0, 0, 0);
        load_image(6);
        for (int n = 0; n < 20; n++) begin
            dma_write(1, $random(seed));
            dma_write(2, $random(seed));
            run_program();
            model_run();
            check_registers();
        end
    endtask

    task automatic run_without_stop();
        int     pick;
        instr_t word;
        for (int i = 0; i < PROG_DEPTH; i++) begin
            pick = $unsigned($random(seed)) % 9;
            word = $random(seed);
            // Code 0 would be a stop, so it stands in for an unused code
            prog_image[i] = {(pick == 0) ? 4'hd : 4'(pick), word[27:0]};
        end
        load_image(PROG_DEPTH);
        run_program();
        model_run();
        check_registers();
    endtask

    initial begin
        wb_cyc            <= 1'b0;
        wb_stb            <= 1'b0;
        wb_we             <= 1'b0;
        wb_adr            <= '0;
        wb_write_data     <= '0;
        run               <= 1'b0;
        dma_write_valid   <= 1'b0;
        dma_write_address <= '0;
        dma_write_data    <= '0;
        dma_read_valid    <= 1'b0;
        dma_read_address  <= '0;
        reset             <= 1'b1;
        for (int r = 0; r < REG_COUNT; r++)
            model_regs[r] = '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        compare_flag("busy", 1'b0, busy);
        compare_flag("dma_write_ready", 1'b1, dma_write_ready);
        compare_flag("wb_ack", 1'b0, wb_ack);
        compare_flag("wb_err", 1'b0, wb_err);
        compare_flag("done", 1'b0, done);
        compare_flag("dma_read_response_valid", 1'b0, dma_read_response_valid);

        program_readback();
        out_of_range_access();
        all_opcodes();
        busy_backpressure();
        random_runs();
        run_without_stop();

        $display("value errors %0d, timeouts %0d, assertion failures %0d",
                 value_errors, timeouts, DUT.handshake_chk.assertion_failures);
        if (value_errors == 0 && timeouts == 0 && DUT.handshake_chk.assertion_failures == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule
